/* Bender.yml */
package:
  name: jtframe_io

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - jtframe_cmd_pkg.sv
      - jtframe_board_pkg.sv
      - jtframe_cmd_decode.sv
      - jtframe_cmd_exec.sv
      - jtframe_board_map.sv
      - jtframe_io_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_jtframe_io.sv

/* jtframe_board_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_defs.svh"

module jtframe_board_map
    import jtframe_board_pkg::*;
#(
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1,
    parameter bit THREE_BUTTONS          = 1'b0
)(
    input  wire                            clk_sys,
    input  wire                            rst,
    input  wire frame_state_t              state,
    // Game inputs
    output logic [`JTFRAME_GAME_JOY_W-1:0] game_joystick1,
    output logic [`JTFRAME_GAME_JOY_W-1:0] game_joystick2,
    output logic [1:0]                     game_coin,
    output logic [1:0]                     game_start,
    output logic                           game_pause,
    output logic                           game_service,
    // Settings and board status
    output dip_t                           dip,
    output logic                           game_rst,
    output logic                           led
);

    dip_t dip_next;
    logic game_rst_next;

    // Buttons above the directions, polarity set by the game
    function automatic logic [`JTFRAME_GAME_JOY_W-1:0] map_joy(input board_joy_t joy);
        logic [5:0] btn;
        btn = joy.buttons;
        if (THREE_BUTTONS) begin
            btn[5:3] = 3'b000;
        end
        return {btn, joy.dirs} ^ {`JTFRAME_GAME_JOY_W{GAME_INPUTS_ACTIVE_LOW}};
    endfunction

    always_comb begin
        dip_next.vertical_n = state.status[2];
        dip_next.test       = state.status[3];
        dip_next.pause      = state.status[4];
        dip_next.flip       = state.status[5];
        dip_next.fxlevel    = state.status[7:6];
        // OSD stores disables, the game wants enables
        dip_next.enable_fm  = ~state.status[8];
        dip_next.enable_psg = ~state.status[9];
    end

    // Game held in reset by the board, the OSD or a ROM load
    assign game_rst_next = rst | state.status[0] | state.downloading;

    always_ff @(posedge clk_sys) begin
        game_joystick1 <= map_joy(state.joy1);
        game_joystick2 <= map_joy(state.joy2);
        game_coin      <= {state.joy2.coin, state.joy1.coin} ^ {2{GAME_INPUTS_ACTIVE_LOW}};
        game_start     <= {state.joy2.start, state.joy1.start} ^ {2{GAME_INPUTS_ACTIVE_LOW}};
        game_pause     <= state.joy1.pause | state.joy2.pause | dip_next.pause;
        game_service   <= state.joy1.service | state.joy2.service;
        dip            <= dip_next;
        game_rst       <= game_rst_next;
        // LED off while loading or in reset
        led            <= ~(state.downloading | game_rst_next);
    end

endmodule

`default_nettype wire

/* jtframe_board_pkg.sv */
`default_nettype none

`include "jtframe_defs.svh"

package jtframe_board_pkg;

    // MiST joystick word, right sits in bit 0
    typedef struct packed {
        logic [1:0] spare;
        logic       service;
        logic       pause;
        logic       coin;
        logic       start;
        logic [5:0] buttons;
        logic [3:0] dirs;      // up, down, left, right
    } board_joy_t;

    // Everything the I/O controller can set
    typedef struct packed {
        logic [31:0]                  status;
        board_joy_t                   joy1;
        board_joy_t                   joy2;
        logic                         downloading;
        logic [`JTFRAME_IOCTL_AW-1:0] ioctl_addr;
        logic [7:0]                   ioctl_data;
        logic                         ioctl_wr;
    } frame_state_t;

    // Game settings taken from the OSD status word
    typedef struct packed {
        logic       test;
        logic       pause;
        logic       flip;
        logic [1:0] fxlevel;
        logic       enable_fm;
        logic       enable_psg;
        logic       vertical_n;
    } dip_t;

endpackage

`default_nettype wire

/* jtframe_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_defs.svh"

module jtframe_cmd_decode
    import jtframe_cmd_pkg::*;
    import jtframe_board_pkg::*;
(
    input  wire                        clk_sys,
    input  wire                        rst,
    // APB slave, no wait states
    input  wire [`JTFRAME_APB_AW-1:0]  paddr,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire [31:0]                 pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    // Frame state for read-back
    input  wire frame_state_t          state,
    output frame_cmd_t                 cmd
);

    cmd_op_e op;
    logic    access;
    logic    dl_only;
    logic    err;
    logic    wr_ok;

    assign access = psel & penable;

    always_comb begin
        case (paddr)
            `JTFRAME_REG_STATUS:   op = CMD_STATUS;
            `JTFRAME_REG_JOY1:     op = CMD_JOY1;
            `JTFRAME_REG_JOY2:     op = CMD_JOY2;
            `JTFRAME_REG_DL_START: op = CMD_DL_START;
            `JTFRAME_REG_DL_DATA:  op = CMD_DL_DATA;
            `JTFRAME_REG_DL_END:   op = CMD_DL_END;
            default:               op = CMD_NONE;
        endcase
    end

    // Data and end writes only make sense inside a download
    assign dl_only = (op == CMD_DL_DATA) || (op == CMD_DL_END);
    assign err     = (op == CMD_NONE) || (pwrite && dl_only && !state.downloading);
    assign wr_ok   = access && pwrite && !err;

    assign pready  = access;
    assign pslverr = access && err;

    always_comb begin
        case (op)
            CMD_STATUS:   prdata = state.status;
            CMD_JOY1:     prdata = {{(32-`JTFRAME_BOARD_JOY_W){1'b0}}, state.joy1};
            CMD_JOY2:     prdata = {{(32-`JTFRAME_BOARD_JOY_W){1'b0}}, state.joy2};
            // Address in 31:8, busy flag in bit 0
            CMD_DL_START: prdata = {{(24-`JTFRAME_IOCTL_AW){1'b0}}, state.ioctl_addr,
                                    7'd0, state.downloading};
            default:      prdata = 32'd0;
        endcase
    end

    // One-cycle command after the access phase
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= wr_ok;
            if (wr_ok) begin
                cmd.op   <= op;
                cmd.data <= pwdata;
            end
        end
    end

endmodule

`default_nettype wire

/* jtframe_cmd_exec.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_defs.svh"

module jtframe_cmd_exec
    import jtframe_cmd_pkg::*;
    import jtframe_board_pkg::*;
(
    input  wire                clk_sys,
    input  wire                rst,
    input  wire frame_cmd_t    cmd,
    output frame_state_t       state
);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            state.status      <= 32'd0;
            state.joy1        <= '0;
            state.joy2        <= '0;
            state.downloading <= 1'b0;
            state.ioctl_addr  <= '0;
            state.ioctl_wr    <= 1'b0;
        end else begin
            // Write strobe lasts a single cycle
            state.ioctl_wr <= 1'b0;

            // Step to the next byte once the strobe has been seen
            if (state.ioctl_wr) begin
                state.ioctl_addr <= state.ioctl_addr + 1'b1;
            end

            if (cmd.valid) begin
                case (cmd.op)
                    CMD_STATUS: begin
                        state.status <= cmd.data;
                    end
                    CMD_JOY1: begin
                        state.joy1 <= board_joy_t'(cmd.data[`JTFRAME_BOARD_JOY_W-1:0]);
                    end
                    CMD_JOY2: begin
                        state.joy2 <= board_joy_t'(cmd.data[`JTFRAME_BOARD_JOY_W-1:0]);
                    end
                    CMD_DL_START: begin
                        state.downloading <= 1'b1;
                        state.ioctl_addr  <= cmd.data[`JTFRAME_IOCTL_AW-1:0];
                    end
                    CMD_DL_DATA: begin
                        state.ioctl_data <= cmd.data[7:0];
                        state.ioctl_wr   <= 1'b1;
                    end
                    CMD_DL_END: begin
                        state.downloading <= 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* jtframe_cmd_pkg.sv */
`default_nettype none

package jtframe_cmd_pkg;

    // One opcode per APB register
    typedef enum logic [2:0] {
        CMD_NONE     = 3'd0,
        CMD_STATUS   = 3'd1,
        CMD_JOY1     = 3'd2,
        CMD_JOY2     = 3'd3,
        CMD_DL_START = 3'd4,
        CMD_DL_DATA  = 3'd5,
        CMD_DL_END   = 3'd6
    } cmd_op_e;

    // Accepted write, handed from decoder to executor
    typedef struct packed {
        logic        valid;
        cmd_op_e     op;
        logic [31:0] data;
    } frame_cmd_t;

endpackage

`default_nettype wire

/* jtframe_defs.svh */
`ifndef JTFRAME_DEFS_SVH
`define JTFRAME_DEFS_SVH

// APB register window
`define JTFRAME_APB_AW          8

`define JTFRAME_REG_STATUS      8'h00
`define JTFRAME_REG_JOY1        8'h04
`define JTFRAME_REG_JOY2        8'h08
`define JTFRAME_REG_DL_START    8'h0C
`define JTFRAME_REG_DL_DATA     8'h10
`define JTFRAME_REG_DL_END      8'h14

// ROM download port
`define JTFRAME_IOCTL_AW        23

// Joystick widths, board side and game side
`define JTFRAME_BOARD_JOY_W     16
`define JTFRAME_GAME_JOY_W      10

`endif

/* jtframe_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_defs.svh"

module jtframe_io_top
    import jtframe_cmd_pkg::*;
    import jtframe_board_pkg::*;
#(
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1,
    parameter bit THREE_BUTTONS          = 1'b0
)(
    input  wire                           clk_sys,
    input  wire                           rst,
    // APB from the I/O controller
    input  wire [`JTFRAME_APB_AW-1:0]     paddr,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire [31:0]                    pwdata,
    output wire [31:0]                    prdata,
    output wire                           pready,
    output wire                           pslverr,
    // ROM load
    output wire [`JTFRAME_IOCTL_AW-1:0]   ioctl_addr,
    output wire [7:0]                     ioctl_data,
    output wire                           ioctl_wr,
    output wire                           downloading,
    output wire [31:0]                    status,
    // Game side
    output wire [`JTFRAME_GAME_JOY_W-1:0] game_joystick1,
    output wire [`JTFRAME_GAME_JOY_W-1:0] game_joystick2,
    output wire [1:0]                     game_coin,
    output wire [1:0]                     game_start,
    output wire                           game_pause,
    output wire                           game_service,
    output dip_t                          dip,
    output wire                           game_rst,
    output wire                           led
);

    frame_cmd_t   cmd;
    frame_state_t state;

    assign ioctl_addr  = state.ioctl_addr;
    assign ioctl_data  = state.ioctl_data;
    assign ioctl_wr    = state.ioctl_wr;
    assign downloading = state.downloading;
    assign status      = state.status;

    jtframe_cmd_decode u_decode (
        .clk_sys ( clk_sys ),
        .rst     ( rst     ),
        .paddr   ( paddr   ),
        .psel    ( psel    ),
        .penable ( penable ),
        .pwrite  ( pwrite  ),
        .pwdata  ( pwdata  ),
        .prdata  ( prdata  ),
        .pready  ( pready  ),
        .pslverr ( pslverr ),
        .state   ( state   ),
        .cmd     ( cmd     )
    );

    jtframe_cmd_exec u_exec (
        .clk_sys ( clk_sys ),
        .rst     ( rst     ),
        .cmd     ( cmd     ),
        .state   ( state   )
    );

    jtframe_board_map #(
        .GAME_INPUTS_ACTIVE_LOW ( GAME_INPUTS_ACTIVE_LOW ),
        .THREE_BUTTONS          ( THREE_BUTTONS          )
    ) u_board (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .state          ( state          ),
        .game_joystick1 ( game_joystick1 ),
        .game_joystick2 ( game_joystick2 ),
        .game_coin      ( game_coin      ),
        .game_start     ( game_start     ),
        .game_pause     ( game_pause     ),
        .game_service   ( game_service   ),
        .dip            ( dip            ),
        .game_rst       ( game_rst       ),
        .led            ( led            )
    );

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
jtframe_cmd_pkg.sv
jtframe_board_pkg.sv
jtframe_cmd_decode.sv
jtframe_cmd_exec.sv
jtframe_board_map.sv
jtframe_io_top.sv
tb_jtframe_io.sv

/* tb_jtframe_io.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_defs.svh"

module tb_jtframe_io
    import jtframe_board_pkg::*;
();

    logic                           clk_sys;
    logic                           rst;
    logic [`JTFRAME_APB_AW-1:0]     paddr;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [31:0]                    pwdata;
    wire  [31:0]                    prdata;
    wire                            pready;
    wire                            pslverr;
    wire  [`JTFRAME_IOCTL_AW-1:0]   ioctl_addr;
    wire  [7:0]                     ioctl_data;
    wire                            ioctl_wr;
    wire                            downloading;
    wire  [31:0]                    status;
    wire  [`JTFRAME_GAME_JOY_W-1:0] game_joystick1;
    wire  [`JTFRAME_GAME_JOY_W-1:0] game_joystick2;
    wire  [1:0]                     game_coin;
    wire  [1:0]                     game_start;
    wire                            game_pause;
    wire                            game_service;
    dip_t                           dip;
    wire                            game_rst;
    wire                            led;

    integer seed = 32'h41f6;
    int     errors = 0;
    int     pulses = 0;
    int     bytes_sent = 0;

    // Register model
    logic [31:0]                  m_status;
    logic [15:0]                  m_joy1;
    logic [15:0]                  m_joy2;
    logic                         m_dl;
    logic [`JTFRAME_IOCTL_AW-1:0] m_addr;
    logic [7:0]                   exp_bytes[$];
    logic [`JTFRAME_IOCTL_AW-1:0] exp_addrs[$];

    jtframe_io_top jtframe_io_top_inst (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .paddr          ( paddr          ),
        .psel           ( psel           ),
        .penable        ( penable        ),
        .pwrite         ( pwrite         ),
        .pwdata         ( pwdata         ),
        .prdata         ( prdata         ),
        .pready         ( pready         ),
        .pslverr        ( pslverr        ),
        .ioctl_addr     ( ioctl_addr     ),
        .ioctl_data     ( ioctl_data     ),
        .ioctl_wr       ( ioctl_wr       ),
        .downloading    ( downloading    ),
        .status         ( status         ),
        .game_joystick1 ( game_joystick1 ),
        .game_joystick2 ( game_joystick2 ),
        .game_coin      ( game_coin      ),
        .game_start     ( game_start     ),
        .game_pause     ( game_pause     ),
        .game_service   ( game_service   ),
        .dip            ( dip            ),
        .game_rst       ( game_rst       ),
        .led            ( led            )
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    task automatic finish_run;
        $display("Run finished: %0d errors, %0d ioctl writes seen", errors, pulses);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test, field, exp, act);
        end
    endtask

    // Download strobe monitor, one pulse per accepted byte
    always @(negedge clk_sys) begin
        if (!rst && ioctl_wr === 1'b1) begin
            pulses++;
            if (exp_bytes.size() == 0) begin
                errors++;
                $display("ioctl_wr pulsed with no byte pending");
            end else begin
                check_value("download", "ioctl_data", exp_bytes.pop_front(), ioctl_data);
                check_value("download", "ioctl_addr", exp_addrs.pop_front(), ioctl_addr);
            end
        end
    end

    // Called at 2 ns after a rising edge, returns at the same point
    task automatic apb_access(input logic [7:0] addr, input logic write,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int   wait_cnt;
        logic seen;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk_sys);
        #2;
        penable  = 1'b1;
        seen     = 1'b0;
        wait_cnt = 0;
        while (!seen && wait_cnt < 16) begin
            @(negedge clk_sys);
            if (pready === 1'b1) begin
                seen = 1'b1;
            end else begin
                wait_cnt++;
            end
        end
        if (!seen) begin
            errors++;
            $display("APB access to offset %h never saw pready", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_sys);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    function automatic logic [31:0] model_read(input logic [7:0] addr);
        case (addr)
            `JTFRAME_REG_STATUS:   return m_status;
            `JTFRAME_REG_JOY1:     return {16'd0, m_joy1};
            `JTFRAME_REG_JOY2:     return {16'd0, m_joy2};
            `JTFRAME_REG_DL_START: return {1'b0, m_addr, 7'd0, m_dl};
            default:               return 32'd0;
        endcase
    endfunction

    function automatic logic is_mapped(input logic [7:0] addr);
        return addr == `JTFRAME_REG_STATUS || addr == `JTFRAME_REG_JOY1 ||
               addr == `JTFRAME_REG_JOY2 || addr == `JTFRAME_REG_DL_START ||
               addr == `JTFRAME_REG_DL_DATA || addr == `JTFRAME_REG_DL_END;
    endfunction

    task automatic check_outputs(input string test);
        dip_t                           exp_dip;
        logic                           exp_rst;
        logic                           exp_led;
        logic [`JTFRAME_GAME_JOY_W-1:0] exp_joy1;
        logic [`JTFRAME_GAME_JOY_W-1:0] exp_joy2;
        logic [1:0]                     exp_coin;
        logic [1:0]                     exp_start;
        exp_dip.vertical_n = m_status[2];
        exp_dip.test       = m_status[3];
        exp_dip.pause      = m_status[4];
        exp_dip.flip       = m_status[5];
        exp_dip.fxlevel    = m_status[7:6];
        exp_dip.enable_fm  = ~m_status[8];
        exp_dip.enable_psg = ~m_status[9];
        exp_rst = m_status[0] | m_dl;
        exp_led = ~exp_rst;
        // Active-low game inputs, buttons above directions
        exp_joy1  = ~m_joy1[9:0];
        exp_joy2  = ~m_joy2[9:0];
        exp_coin  = ~{m_joy2[11], m_joy1[11]};
        exp_start = ~{m_joy2[10], m_joy1[10]};
        check_value(test, "game_joystick1", exp_joy1, game_joystick1);
        check_value(test, "game_joystick2", exp_joy2, game_joystick2);
        check_value(test, "game_coin", exp_coin, game_coin);
        check_value(test, "game_start", exp_start, game_start);
        check_value(test, "game_pause", m_joy1[12] | m_joy2[12] | m_status[4], game_pause);
        check_value(test, "game_service", m_joy1[13] | m_joy2[13], game_service);
        check_value(test, "dip", exp_dip, dip);
        check_value(test, "game_rst", exp_rst, game_rst);
        check_value(test, "led", exp_led, led);
        check_value(test, "downloading", m_dl, downloading);
        check_value(test, "status", m_status, status);
    endtask

    task automatic write_reg(input string test, input logic [7:0] addr,
                             input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        logic        exp_err;
        exp_err = !is_mapped(addr) ||
                  ((addr == `JTFRAME_REG_DL_DATA || addr == `JTFRAME_REG_DL_END) && !m_dl);
        apb_access(addr, 1'b1, data, rdata, err);
        check_value(test, "pslverr", exp_err, err);
        if (!exp_err) begin
            case (addr)
                `JTFRAME_REG_STATUS:   m_status = data;
                `JTFRAME_REG_JOY1:     m_joy1 = data[15:0];
                `JTFRAME_REG_JOY2:     m_joy2 = data[15:0];
                `JTFRAME_REG_DL_START: begin
                    m_dl   = 1'b1;
                    m_addr = data[`JTFRAME_IOCTL_AW-1:0];
                end
                `JTFRAME_REG_DL_DATA: begin
                    exp_bytes.push_back(data[7:0]);
                    exp_addrs.push_back(m_addr);
                    bytes_sent++;
                    m_addr = m_addr + 1'b1;
                end
                `JTFRAME_REG_DL_END:   m_dl = 1'b0;
                default: begin
                end
            endcase
        end
        // Outputs settle two edges after the access
        repeat (3) @(posedge clk_sys);
        #2;
        check_outputs(test);
    endtask

    task automatic read_check(input string test, input logic [7:0] addr);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b0, 32'd0, rdata, err);
        check_value(test, "read pslverr", 32'd0, err);
        check_value(test, "read data", model_read(addr), rdata);
    endtask

    task automatic read_all(input string test);
        read_check(test, `JTFRAME_REG_STATUS);
        read_check(test, `JTFRAME_REG_JOY1);
        read_check(test, `JTFRAME_REG_JOY2);
        read_check(test, `JTFRAME_REG_DL_START);
        read_check(test, `JTFRAME_REG_DL_DATA);
        read_check(test, `JTFRAME_REG_DL_END);
    endtask

    // Hang guard
    initial begin
        #2ms;
        errors++;
        $display("Simulation ran past its time limit");
        finish_run();
    end

    initial begin
        logic [7:0]  addr;
        logic [31:0] rdata;
        logic        err;
        int          sel;
        rst      = 1'b1;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        m_status = '0;
        m_joy1   = '0;
        m_joy2   = '0;
        m_dl     = 1'b0;
        m_addr   = '0;

        // Reset held for three cycles
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("reset", "downloading", 32'd0, downloading);
        check_value("reset", "ioctl_wr", 32'd0, ioctl_wr);
        check_value("reset", "game_rst", 32'd1, game_rst);
        check_value("reset", "led", 32'd0, led);
        @(posedge clk_sys);
        #2;
        rst = 1'b0;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("reset", "game_rst", 32'd0, game_rst);
        check_value("reset", "led", 32'd1, led);
        check_value("reset", "pready", 32'd0, pready);
        check_value("reset", "pslverr", 32'd0, pslverr);
        @(posedge clk_sys);
        #2;
        read_all("reset");

        for (int i = 0; i < 20; i++) begin
            sel = $unsigned($random(seed)) % 3;
            addr = (sel == 0) ? `JTFRAME_REG_STATUS :
                   (sel == 1) ? `JTFRAME_REG_JOY1 : `JTFRAME_REG_JOY2;
            write_reg("readback", addr, $random(seed));
            read_check("readback", `JTFRAME_REG_STATUS);
            read_check("readback", `JTFRAME_REG_JOY1);
            read_check("readback", `JTFRAME_REG_JOY2);
        end

        for (int i = 0; i < 20; i++) begin
            write_reg("joystick", `JTFRAME_REG_JOY1, $random(seed));
            write_reg("joystick", `JTFRAME_REG_JOY2, $random(seed));
        end

        for (int i = 0; i < 20; i++) begin
            write_reg("dip", `JTFRAME_REG_STATUS, $random(seed));
        end

        // ROM load with the game out of OSD reset
        write_reg("download", `JTFRAME_REG_STATUS, 32'h0);
        write_reg("download", `JTFRAME_REG_DL_START, $random(seed));
        read_check("download", `JTFRAME_REG_DL_START);
        for (int i = 0; i < 16; i++) begin
            write_reg("download", `JTFRAME_REG_DL_DATA, $random(seed));
        end
        read_check("download", `JTFRAME_REG_DL_START);
        write_reg("download", `JTFRAME_REG_DL_END, $random(seed));
        read_check("download", `JTFRAME_REG_DL_START);
        check_value("download", "pending bytes", 32'd0, exp_bytes.size());
        check_value("download", "ioctl_wr pulses", bytes_sent, pulses);

        for (int i = 0; i < 10; i++) begin
            addr = $random(seed);
            if (is_mapped(addr)) begin
                addr = addr ^ 8'h01;
            end
            apb_access(addr, $random(seed), $random(seed), rdata, err);
            check_value("errors", "unmapped pslverr", 32'd1, err);
        end
        write_reg("errors", `JTFRAME_REG_DL_DATA, $random(seed));
        write_reg("errors", `JTFRAME_REG_DL_END, $random(seed));
        read_all("errors");
        check_value("errors", "ioctl_wr pulses", bytes_sent, pulses);

        finish_run();
    end

endmodule

`default_nettype wire
